/* common/rv_core_macros.svh */
// Core sizing macros: word width, register count, queue depth, data memory size
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Integer word width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NUM_REGS 32

// Instruction queue entries
`define RV_QUEUE_DEPTH 8

// Data memory size in words
`define RV_DMEM_WORDS 64

`endif

/* common/rv_core_pkg.sv */
// Core package: opcode enum, instruction word union, forward select enum, immediate functions
`default_nettype none
`include "rv_core_macros.svh"

package rv_core_pkg;

    // Major opcodes handled by the pipeline
    // Anything else retires without a write
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    // R layout, also the source of the I and U fields
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_view_t;

    // S layout, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_view_t;

    // One word, two decodings
    typedef union packed {
        r_view_t r;
        s_view_t s;
    } instr_word_t;

    // Operand source chosen in ID
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_EX   = 2'b01,
        FWD_MEM  = 2'b10,
        FWD_WAIT = 2'b11
    } fwd_sel_t;

    // I immediate, bits 31:20 sign extended
    function automatic logic [`RV_XLEN-1:0] imm_i(input instr_word_t w);
        return {{20{w.r.funct7[6]}}, w.r.funct7, w.r.rs2};
    endfunction

    // S immediate, hi and lo parts joined
    function automatic logic [`RV_XLEN-1:0] imm_s(input instr_word_t w);
        return {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
    endfunction

    // U immediate, upper 20 bits with zero low part
    function automatic logic [`RV_XLEN-1:0] imm_u(input instr_word_t w);
        return {w.r.funct7, w.r.rs2, w.r.rs1, w.r.funct3, 12'b0};
    endfunction

endpackage

`default_nettype wire

/* common/stage_bus_if.sv */
// Stage-to-stage bundle interface with driver, receiver and forwarding modports
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

interface stage_bus_if;
    import rv_core_pkg::*;

    logic               valid;
    instr_word_t        instr;
    logic [4:0]         rd;
    // Low when the instruction writes rd
    logic               wr_reg_n;
    logic [`RV_XLEN-1:0] val_a;
    logic [`RV_XLEN-1:0] val_b;
    // ALU value or address, ex_mem only
    logic [`RV_XLEN-1:0] result;
    opcode_t            opcode;

    // Opcode view for the forwarding logic
    assign opcode = instr.r.opcode;

    modport src (output valid, instr, rd, wr_reg_n, val_a, val_b, result);
    modport dst (input valid, instr, rd, wr_reg_n, val_a, val_b, result);
    // Hazard view only
    modport fwd (input valid, rd, wr_reg_n, opcode);

endinterface

`default_nettype wire

/* source/instr_queue.sv */
// Instruction FIFO with sticky overflow flag and occupancy assertions
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module instr_queue (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  rv_core_pkg::instr_word_t push_instr,
    input  logic                     pop,
    output rv_core_pkg::instr_word_t head,
    output logic                     head_valid,
    output logic                     overflow
);
    import rv_core_pkg::*;

    localparam int DEPTH = `RV_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    instr_word_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             accept;

    assign full       = (count == CNT_W'(DEPTH));
    // Push while full is lost
    assign accept     = push && !full;
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr] <= push_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Count moves only on a one-sided transfer
            if (accept && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !accept) begin
                count <= count - 1'b1;
            end
            // Sticky until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // Decode must only pop a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid);

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

/* pipeline/operand_forward.sv */
// Operand forward select per source register from EX and MEM destinations
`timescale 1ns/1ns
`default_nettype none

module operand_forward (
    input  logic                  [4:0] rs1,
    input  logic                  [4:0] rs2,
    stage_bus_if.fwd                    ex,
    stage_bus_if.fwd                    mem,
    output rv_core_pkg::fwd_sel_t       sel_a,
    output rv_core_pkg::fwd_sel_t       sel_b
);
    import rv_core_pkg::*;

    logic ex_writes;
    logic mem_writes;
    logic ex_is_load;

    // Only valid instructions that really write rd count
    assign ex_writes  = ex.valid && !ex.wr_reg_n;
    assign mem_writes = mem.valid && !mem.wr_reg_n;
    // Load data exists only once the load reaches MEM
    assign ex_is_load = (ex.opcode == LOAD);

    // EX is younger than MEM, so EX is checked first
    function automatic fwd_sel_t resolve(
        input logic [4:0] rs,
        input logic       ex_wr,
        input logic [4:0] ex_rd,
        input logic       ex_load,
        input logic       mem_wr,
        input logic [4:0] mem_rd
    );
        fwd_sel_t sel;
        if (rs == 5'd0) begin
            // x0 is constant zero
            sel = FWD_NONE;
        end else if (ex_wr && (rs == ex_rd)) begin
            sel = ex_load ? FWD_WAIT : FWD_EX;
        end else if (mem_wr && (rs == mem_rd)) begin
            sel = FWD_MEM;
        end else begin
            // Register file already current
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    // rs2 is resolved even for formats without it
    assign sel_a = resolve(rs1, ex_writes, ex.rd, ex_is_load, mem_writes, mem.rd);
    assign sel_b = resolve(rs2, ex_writes, ex.rd, ex_is_load, mem_writes, mem.rd);

endmodule

`default_nettype wire

/* pipeline/decode_stage.sv */
// ID stage: register file, load-use stall, operand muxing and the ID/EX register
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv_core_pkg::instr_word_t head,
    input  logic                     head_valid,
    output logic                     pop,
    input  logic [`RV_XLEN-1:0]      ex_result,
    input  logic [`RV_XLEN-1:0]      mem_result,
    stage_bus_if.fwd                 ex_fwd,
    stage_bus_if.fwd                 mem_fwd,
    input  logic                     wb_en,
    input  logic [4:0]               wb_rd,
    input  logic [`RV_XLEN-1:0]      wb_data,
    stage_bus_if.src                 out
);
    import rv_core_pkg::*;

    localparam int NREGS = `RV_NUM_REGS;

    // x1..x31 only, x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:NREGS-1];
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] rf_a;
    logic [`RV_XLEN-1:0] rf_b;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    fwd_sel_t            sel_a;
    fwd_sel_t            sel_b;
    logic                stall;
    logic                writes_rd;

    assign rs1 = head.r.rs1;
    assign rs2 = head.r.rs2;

    operand_forward u_fwd (
        .rs1   (rs1),
        .rs2   (rs2),
        .ex    (ex_fwd),
        .mem   (mem_fwd),
        .sel_a (sel_a),
        .sel_b (sel_b)
    );

    // Load-use hazard holds the head in place
    assign stall = head_valid && ((sel_a == FWD_WAIT) || (sel_b == FWD_WAIT));
    assign pop   = head_valid && !stall;

    // Register file read, x0 reads as zero
    assign rf_a = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rf_b = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_comb begin
        case (sel_a)
            FWD_EX:  op_a = ex_result;
            FWD_MEM: op_a = mem_result;
            default: op_a = rf_a;
        endcase
        case (sel_b)
            FWD_EX:  op_b = ex_result;
            FWD_MEM: op_b = mem_result;
            default: op_b = rf_b;
        endcase
    end

    // Only these opcodes update rd, and never x0
    assign writes_rd = (head.r.opcode inside {LUI, OP_IMM, OP, LOAD}) && (head.r.rd != 5'd0);

    // Writeback from MEM at the end of its cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != 5'd0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // ID/EX control, bubble when nothing is popped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid    <= 1'b0;
            out.wr_reg_n <= 1'b1;
        end else begin
            out.valid    <= pop;
            out.wr_reg_n <= !writes_rd;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        out.instr  <= head;
        out.rd     <= head.r.rd;
        out.val_a  <= op_a;
        out.val_b  <= op_b;
        out.result <= '0;
    end

    // Stalled head is still the head next cycle
    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> head_valid && $stable(head));

endmodule

`default_nettype wire

/* pipeline/execute_stage.sv */
// EX stage: ALU, load/store address adder and the EX/MEM register
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    stage_bus_if.dst            in,
    stage_bus_if.src            out,
    output logic [`RV_XLEN-1:0] ex_result
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu;
    logic [2:0]          funct3;
    logic                is_sub;
    logic                lt;

    assign funct3 = in.instr.r.funct3;
    // SUB only exists in the register form
    assign is_sub = (in.instr.r.opcode == OP) && in.instr.r.funct7[5];
    // Register or immediate second operand
    assign op_b   = (in.instr.r.opcode == OP) ? in.val_b : imm_i(in.instr);
    assign lt     = $signed(in.val_a) < $signed(op_b);

    always_comb begin
        case (in.instr.r.opcode)
            LUI: alu = imm_u(in.instr);
            OP, OP_IMM: begin
                case (funct3)
                    3'b000:  alu = is_sub ? (in.val_a - op_b) : (in.val_a + op_b);
                    3'b001:  alu = in.val_a << op_b[4:0];
                    3'b010:  alu = {{(`RV_XLEN-1){1'b0}}, lt};
                    3'b100:  alu = in.val_a ^ op_b;
                    // Logical shift only, no arithmetic form
                    3'b101:  alu = in.val_a >> op_b[4:0];
                    3'b110:  alu = in.val_a | op_b;
                    3'b111:  alu = in.val_a & op_b;
                    default: alu = '0;
                endcase
            end
            // Byte address, MEM drops the low bits
            LOAD:    alu = in.val_a + imm_i(in.instr);
            STORE:   alu = in.val_a + imm_s(in.instr);
            default: alu = '0;
        endcase
    end

    // Straight to the forwarding mux in ID
    assign ex_result = alu;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid    <= 1'b0;
            out.wr_reg_n <= 1'b1;
        end else begin
            out.valid    <= in.valid;
            out.wr_reg_n <= in.wr_reg_n;
        end
    end

    // val_b carries store data onward
    always_ff @(posedge clk) begin
        out.instr  <= in.instr;
        out.rd     <= in.rd;
        out.val_a  <= in.val_a;
        out.val_b  <= in.val_b;
        out.result <= alu;
    end

endmodule

`default_nettype wire

/* pipeline/memory_stage.sv */
// MEM stage: data memory, load/store, register writeback and retire strobe
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module memory_stage (
    input  logic                clk,
    input  logic                rst_n,
    stage_bus_if.dst            in,
    output logic [`RV_XLEN-1:0] mem_result,
    output logic                wb_en,
    output logic [4:0]          wb_rd,
    output logic [`RV_XLEN-1:0] wb_data,
    output logic                ret_valid,
    output logic [4:0]          ret_rd,
    output logic                ret_wr,
    output logic [`RV_XLEN-1:0] ret_data
);
    import rv_core_pkg::*;

    localparam int WORDS  = `RV_DMEM_WORDS;
    localparam int ADDR_W = $clog2(WORDS);

    logic [`RV_XLEN-1:0] dmem [WORDS];
    logic [ADDR_W-1:0]   addr;
    logic                is_load;
    logic                is_store;

    // Word index, byte offset ignored
    assign addr     = in.result[ADDR_W+1:2];
    assign is_load  = (in.instr.r.opcode == LOAD);
    assign is_store = in.valid && (in.instr.r.opcode == STORE);

    // Combinational read, also feeds the MEM forward path
    assign mem_result = is_load ? dmem[addr] : in.result;

    // Word store at the edge
    always_ff @(posedge clk) begin
        if (rst_n && is_store) begin
            dmem[addr] <= in.val_b;
        end
    end

    // Register file write lands at the end of this cycle
    assign wb_en   = in.valid && !in.wr_reg_n;
    assign wb_rd   = in.rd;
    assign wb_data = mem_result;

    // One strobe per instruction, bubbles excluded
    assign ret_valid = in.valid;
    assign ret_rd    = in.rd;
    assign ret_wr    = wb_en;
    assign ret_data  = mem_result;

    // x0 writes are filtered back in ID
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> (wb_rd != 5'd0));

endmodule

`default_nettype wire

/* source/rv_core_top.sv */
// Core top level: instruction queue, ID/EX/MEM stages and idle detection
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module rv_core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic [31:0]         in_instr,
    output logic                ret_valid,
    output logic [4:0]          ret_rd,
    output logic                ret_wr,
    output logic [`RV_XLEN-1:0] ret_data,
    output logic                idle,
    output logic                overflow
);
    import rv_core_pkg::*;

    instr_word_t         head;
    logic                head_valid;
    logic                pop;
    logic [`RV_XLEN-1:0] ex_result;
    logic [`RV_XLEN-1:0] mem_result;
    logic                wb_en;
    logic [4:0]          wb_rd;
    logic [`RV_XLEN-1:0] wb_data;

    // Stage registers between ID/EX and EX/MEM
    stage_bus_if id_ex ();
    stage_bus_if ex_mem ();

    // No back-pressure, full queue drops
    instr_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (in_valid),
        .push_instr (in_instr),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .overflow   (overflow)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .ex_fwd     (id_ex.fwd),
        .mem_fwd    (ex_mem.fwd),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .out        (id_ex.src)
    );

    execute_stage u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (id_ex.dst),
        .out       (ex_mem.src),
        .ex_result (ex_result)
    );

    memory_stage u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (ex_mem.dst),
        .mem_result (mem_result),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .ret_valid  (ret_valid),
        .ret_rd     (ret_rd),
        .ret_wr     (ret_wr),
        .ret_data   (ret_data)
    );

    // Nothing queued and every stage empty
    assign idle = !head_valid && !id_ex.valid && !ex_mem.valid;

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Testbench clock generator, 40 ns period, with a 2-cycle synchronous reset
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    // 20 ns half period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Low across two rising edges, released just after the second
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/tb_checker.sv */
// Retire monitor: expected retire queue, in-order compare, overflow watch and error counts
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module tb_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                ret_valid,
    input logic [4:0]          ret_rd,
    input logic                ret_wr,
    input logic [`RV_XLEN-1:0] ret_data,
    input logic                overflow
);
    // Expected retires, oldest first
    string               exp_name [$];
    logic [4:0]          exp_rd [$];
    logic                exp_wr [$];
    logic [`RV_XLEN-1:0] exp_data [$];

    int                  value_errors;
    int                  retire_errors;
    int                  overflow_errors;
    logic                overflow_seen;

    // Entry under compare
    string               cur_name;
    logic [4:0]          cur_rd;
    logic                cur_wr;
    logic [`RV_XLEN-1:0] cur_data;

    initial begin
        value_errors    = 0;
        retire_errors   = 0;
        overflow_errors = 0;
        overflow_seen   = 1'b0;
    end

    // Called by the stimulus for each issued instruction
    function automatic void expect_retire(input string name, input logic [4:0] rd,
                                          input logic wr, input logic [`RV_XLEN-1:0] data);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_wr.push_back(wr);
        exp_data.push_back(data);
    endfunction

    // With the core idle every issued instruction must have retired
    function automatic void check_drained(input string where);
        if (exp_rd.size() != 0) begin
            $display("Missing retires: %0d instructions never retired after %s",
                     exp_rd.size(), where);
            retire_errors += exp_rd.size();
            exp_name.delete();
            exp_rd.delete();
            exp_wr.delete();
            exp_data.delete();
        end
    endfunction

    // Sampled mid-cycle, well clear of the input drive point
    always @(negedge clk) begin
        if (rst_n && overflow && !overflow_seen) begin
            $display("Queue overflow: an instruction was dropped by the DUT");
            overflow_errors++;
            overflow_seen = 1'b1;
        end
        if (rst_n && ret_valid) begin
            if (exp_rd.size() == 0) begin
                $display("Unexpected retire: x%0d retired with nothing outstanding", ret_rd);
                retire_errors++;
            end else begin
                cur_name = exp_name.pop_front();
                cur_rd   = exp_rd.pop_front();
                cur_wr   = exp_wr.pop_front();
                cur_data = exp_data.pop_front();
                if (ret_rd !== cur_rd) begin
                    $display("[ERROR] %s rd: expected %0d, actual %0d", cur_name, cur_rd, ret_rd);
                    value_errors++;
                end
                if (ret_wr !== cur_wr) begin
                    $display("[ERROR] %s wr: expected %0b, actual %0b", cur_name, cur_wr, ret_wr);
                    value_errors++;
                end
                // Data only defined when rd is written
                if (cur_wr && (ret_data !== cur_data)) begin
                    $display("[ERROR] %s data x%0d: expected %08h, actual %08h",
                             cur_name, cur_rd, cur_data, ret_data);
                    value_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_top.sv */
// Testbench top: DUT instance, RV32I reference model, directed and random stimulus
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module tb_top;
    import rv_core_pkg::*;

    // Cycles allowed for any single wait
    localparam int WAIT_LIMIT = 50;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    logic [31:0]         in_instr;
    logic                ret_valid;
    logic [4:0]          ret_rd;
    logic                ret_wr;
    logic [`RV_XLEN-1:0] ret_data;
    logic                idle;
    logic                overflow;

    // Model state, updated in program order
    logic [`RV_XLEN-1:0] mregs [`RV_NUM_REGS];
    logic [`RV_XLEN-1:0] mdmem [`RV_DMEM_WORDS];
    int                  timeout_errors;
    int                  total_errors;

    tb_clock_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_core_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .ret_valid (ret_valid),
        .ret_rd    (ret_rd),
        .ret_wr    (ret_wr),
        .ret_data  (ret_data),
        .idle      (idle),
        .overflow  (overflow)
    );

    tb_checker chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ret_valid (ret_valid),
        .ret_rd    (ret_rd),
        .ret_wr    (ret_wr),
        .ret_data  (ret_data),
        .overflow  (overflow)
    );

    // Instruction encoders
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Always a word store, funct3 010
    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, LUI};
    endfunction

    // Architectural effect of one instruction on the model state
    function automatic void ref_exec(input logic [31:0] w, output logic [4:0] rd,
                                     output logic wr, output logic [`RV_XLEN-1:0] val);
        logic [6:0]          op;
        logic [2:0]          f3;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] sext_i;
        logic [`RV_XLEN-1:0] sext_s;
        logic [`RV_XLEN-1:0] rhs;
        logic [`RV_XLEN-1:0] addr;
        op     = w[6:0];
        rd     = w[11:7];
        f3     = w[14:12];
        // mregs[0] is never written, so x0 reads zero
        a      = mregs[w[19:15]];
        b      = mregs[w[24:20]];
        sext_i = {{20{w[31]}}, w[31:20]};
        sext_s = {{20{w[31]}}, w[31:25], w[11:7]};
        rhs    = (op == OP) ? b : sext_i;
        wr     = 1'b1;
        val    = '0;
        case (op)
            LUI: val = {w[31:12], 12'b0};
            OP, OP_IMM: begin
                case (f3)
                    // bit 30 selects SUB in the register form only
                    3'd0:    val = ((op == OP) && w[30]) ? (a - rhs) : (a + rhs);
                    3'd1:    val = a << rhs[4:0];
                    3'd2:    val = ($signed(a) < $signed(rhs)) ? 32'd1 : 32'd0;
                    3'd4:    val = a ^ rhs;
                    3'd5:    val = a >> rhs[4:0];
                    3'd6:    val = a | rhs;
                    3'd7:    val = a & rhs;
                    default: val = '0;
                endcase
            end
            LOAD: begin
                addr = a + sext_i;
                val  = mdmem[addr[7:2]];
            end
            STORE: begin
                addr               = a + sext_s;
                mdmem[addr[7:2]]   = b;
                wr                 = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        // x0 is never a destination
        if (rd == 5'd0) begin
            wr = 1'b0;
        end
        if (wr) begin
            mregs[rd] = val;
        end
    endfunction

    // Random LUI, OP-IMM or OP; SLTU and SRAI left out
    function automatic logic [31:0] random_alu();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          r;
        int          kind;
        rd   = 5'($urandom_range(31, 1));
        rs1  = 5'($urandom_range(31, 0));
        rs2  = 5'($urandom_range(31, 0));
        r    = int'($urandom_range(6, 0));
        f3   = 3'((r >= 3) ? r + 1 : r);
        imm  = 12'($urandom);
        kind = int'($urandom_range(2, 0));
        // Shift immediates carry a plain shamt
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin
            imm = {7'b0, imm[4:0]};
        end
        f7 = ((f3 == 3'd0) && ($urandom_range(1, 0) == 1)) ? 7'h20 : 7'h00;
        if (kind == 0) begin
            return encode_u(20'($urandom), rd);
        end else if (kind == 1) begin
            return encode_i(imm, rs1, f3, rd, OP_IMM);
        end
        return encode_r(f7, rs2, rs1, f3, rd);
    endfunction

    // Expectation queued first, strobe set 5 ns after the edge
    task automatic issue(input logic [31:0] w, input string name);
        logic [4:0]          e_rd;
        logic                e_wr;
        logic [`RV_XLEN-1:0] e_val;
        ref_exec(w, e_rd, e_wr, e_val);
        chk_i.expect_retire(name, e_rd, e_wr, e_val);
        @(posedge clk);
        #5;
        in_valid = 1'b1;
        in_instr = w;
    endtask

    // End the burst, then wait for the core to empty
    task automatic drain(input string where);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #5;
        in_valid = 1'b0;
        in_instr = '0;
        @(negedge clk);
        while (!idle && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (!idle) begin
            $display("Timeout: core still busy %0d cycles after the %s burst", WAIT_LIMIT, where);
            timeout_errors++;
        end else begin
            chk_i.check_drained(where);
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (!rst_n && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("Timeout: reset was never released");
            timeout_errors++;
        end
    endtask

    initial begin
        in_valid       = 1'b0;
        in_instr       = '0;
        timeout_errors = 0;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            mdmem[i] = '0;
        end
        void'($urandom(92));
        wait_reset();
        @(negedge clk);
        if (!idle || overflow) begin
            $display("Core not idle, or overflow set, after reset");
            timeout_errors++;
        end

        // Random ALU traffic, bursts of 4
        for (int n = 0; n < 6; n++) begin
            for (int k = 0; k < 4; k++) begin
                issue(random_alu(), "random_alu");
            end
            drain("random_alu");
        end

        // rs1 and rs2 from EX, then EX and MEM together
        issue(encode_i(12'd123, 5'd0, 3'd0, 5'd5, OP_IMM), "forward_ex");
        issue(encode_i(12'hff9, 5'd5, 3'd0, 5'd6, OP_IMM), "forward_ex");
        issue(encode_r(7'h00, 5'd6, 5'd0, 3'd0, 5'd7), "forward_ex");
        issue(encode_r(7'h20, 5'd6, 5'd7, 3'd0, 5'd8), "forward_ex");
        drain("forward_ex");

        // Distance two
        issue(encode_i(12'd11, 5'd0, 3'd0, 5'd10, OP_IMM), "forward_mem");
        issue(encode_i(12'd22, 5'd0, 3'd0, 5'd11, OP_IMM), "forward_mem");
        issue(encode_r(7'h00, 5'd11, 5'd10, 3'd0, 5'd12), "forward_mem");
        issue(encode_i(12'h055, 5'd12, 3'd4, 5'd15, OP_IMM), "forward_mem");
        drain("forward_mem");

        // x13 written in both EX and MEM, the younger value must win
        issue(encode_i(12'd1, 5'd0, 3'd0, 5'd13, OP_IMM), "same_rd");
        issue(encode_i(12'd2, 5'd0, 3'd0, 5'd13, OP_IMM), "same_rd");
        issue(encode_i(12'd5, 5'd13, 3'd0, 5'd14, OP_IMM), "same_rd");
        issue(encode_r(7'h00, 5'd14, 5'd13, 3'd6, 5'd16), "same_rd");
        drain("same_rd");

        // Store then load of the same word
        issue(encode_i(12'h040, 5'd0, 3'd0, 5'd20, OP_IMM), "store_load");
        issue(encode_u(20'($urandom), 5'd21), "store_load");
        issue(encode_s(12'd4, 5'd21, 5'd20), "store_load");
        issue(encode_i(12'd4, 5'd20, 3'd2, 5'd22, LOAD), "store_load");
        drain("store_load");

        // Load-use on rs1, then a store of the forwarded sum
        issue(encode_i(12'd4, 5'd20, 3'd2, 5'd23, LOAD), "load_use");
        issue(encode_i(12'd1, 5'd23, 3'd0, 5'd24, OP_IMM), "load_use");
        issue(encode_r(7'h00, 5'd24, 5'd23, 3'd0, 5'd25), "load_use");
        issue(encode_s(12'd8, 5'd25, 5'd20), "load_use");
        drain("load_use");

        // Load-use on rs2, and back-to-back load-use pairs
        issue(encode_i(12'd8, 5'd20, 3'd2, 5'd26, LOAD), "load_use_rs2");
        issue(encode_r(7'h00, 5'd26, 5'd0, 3'd0, 5'd27), "load_use_rs2");
        issue(encode_i(12'h044, 5'd0, 3'd2, 5'd28, LOAD), "load_use_rs2");
        issue(encode_r(7'h20, 5'd26, 5'd28, 3'd0, 5'd29), "load_use_rs2");
        drain("load_use_rs2");

        // x0 writes dropped, x0 still reads zero
        issue(encode_i(12'd55, 5'd0, 3'd0, 5'd0, OP_IMM), "x0_write");
        issue(encode_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd0), "x0_write");
        issue(encode_i(12'd9, 5'd0, 3'd0, 5'd30, OP_IMM), "x0_write");
        issue(encode_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd31), "x0_write");
        drain("x0_write");

        total_errors = timeout_errors + chk_i.value_errors + chk_i.retire_errors
                       + chk_i.overflow_errors;
        $display("Errors: value %0d, retire %0d, overflow %0d, timeout %0d",
                 chk_i.value_errors, chk_i.retire_errors, chk_i.overflow_errors,
                 timeout_errors);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core.f */
+incdir+common
common/rv_core_pkg.sv
common/stage_bus_if.sv
source/instr_queue.sv
pipeline/operand_forward.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/memory_stage.sv
source/rv_core_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_top.sv

/* Makefile */
# Verilator build and run of the rv_core testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f rv_core.f --top-module tb_top -Mdir obj_dir

run: compile
	obj_dir/Vtb_top | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
